//--- rtl/execPkg.sv
`default_nettype none

package execPkg;

	// Datapath word width
	localparam int WORD_W = 16;

	typedef logic [WORD_W-1:0] dataWord;
	typedef logic [4:0]        opCode;
	typedef logic [1:0]        functCode;
	typedef logic [2:0]        regIndex;

	// Special instructions
	localparam opCode HALT  = 5'b00000;
	localparam opCode NOP   = 5'b00001;
	localparam opCode SIIC  = 5'b00010;
	localparam opCode RTI   = 5'b00011;

	// Jumps
	localparam opCode J     = 5'b00100;
	localparam opCode JR    = 5'b00101;
	localparam opCode JAL   = 5'b00110;
	localparam opCode JALR  = 5'b00111;

	// I-format 1 with destination in bits 7:5
	localparam opCode SUBI  = 5'b01000;
	localparam opCode ADDI  = 5'b01001;
	localparam opCode ANDNI = 5'b01010;
	localparam opCode XORI  = 5'b01011;
	localparam opCode ROLI  = 5'b10100;
	localparam opCode SLLI  = 5'b10101;
	localparam opCode RORI  = 5'b10110;
	localparam opCode SRLI  = 5'b10111;
	localparam opCode ST    = 5'b10000;
	localparam opCode LD    = 5'b10001;
	localparam opCode STU   = 5'b10011;

	// I-format 2 with register in bits 10:8
	localparam opCode BNEZ  = 5'b01100;
	localparam opCode BEQZ  = 5'b01101;
	localparam opCode BLTZ  = 5'b01110;
	localparam opCode BGEZ  = 5'b01111;
	localparam opCode LBI   = 5'b11000;
	localparam opCode SLBI  = 5'b10010;

	// R-format with destination in bits 4:2
	localparam opCode BTR   = 5'b11001;
	localparam opCode ALU_2 = 5'b11010;
	localparam opCode ALU_1 = 5'b11011;
	localparam opCode SEQ   = 5'b11100;
	localparam opCode SLT   = 5'b11101;
	localparam opCode SLE   = 5'b11110;
	localparam opCode SCO   = 5'b11111;

	// Function field under ALU_1
	localparam functCode ADD  = 2'b00;
	localparam functCode SUB  = 2'b01;
	localparam functCode XOR  = 2'b10;
	localparam functCode ANDN = 2'b11;

	// Function field under ALU_2
	localparam functCode ROL = 2'b00;
	localparam functCode SLL = 2'b01;
	localparam functCode ROR = 2'b10;
	localparam functCode SRL = 2'b11;

	// Decode to execute bundle
	typedef struct packed {
		opCode    opcode;
		functCode funct;
		dataWord  operandA;
		dataWord  operandB;
		regIndex  dest;
		logic     invA;
		logic     invB;
		logic     carryIn;
	} decodedOp;

	// Execute output bundle
	typedef struct packed {
		dataWord result;
		regIndex dest;
		logic    err;
		logic    branchTaken;
	} execResult;

endpackage

`default_nettype wire

//--- rtl/shifter.sv
`timescale 1ns/1ns
`default_nettype none

module shifter
	import execPkg::*;
(
	input  dataWord    shiftIn,
	input  logic [3:0] shiftCnt,
	output dataWord    rotLeft,
	output dataWord    rotRight,
	output dataWord    shLeft,
	output dataWord    shRight,
	output dataWord    bitRev
);

	// Word placed twice so rotates fall out of plain shifts
	logic [2*WORD_W-1:0] dbl;
	logic [2*WORD_W-1:0] dblLeft;
	logic [2*WORD_W-1:0] dblRight;

	assign dbl      = {shiftIn, shiftIn};
	assign dblLeft  = dbl << shiftCnt;
	assign dblRight = dbl >> shiftCnt;

	// Upper half after left shift
	assign rotLeft  = dblLeft[2*WORD_W-1:WORD_W];
	// Lower half after right shift
	assign rotRight = dblRight[WORD_W-1:0];

	// Logical shifts with zero fill
	assign shLeft  = shiftIn << shiftCnt;
	assign shRight = shiftIn >> shiftCnt;

	// Bit 0 swaps with bit 15 and so on
	always_comb begin
		for (int i = 0; i < WORD_W; i++) begin
			bitRev[i] = shiftIn[WORD_W-1-i];
		end
	end

endmodule

`default_nettype wire

//--- rtl/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu
	import execPkg::*;
(
	input  decodedOp op,
	output dataWord  result,
	output logic     err,
	output logic     zero,
	output logic     neg
);

	dataWord aIn, bIn, sum;
	logic    cout;
	dataWord rotLeft, rotRight, shLeft, shRight, bitRev;
	logic    signsDiffer, lessThan, lessEq;

	// Optional inversion ahead of the adder
	assign aIn = op.invA ? ~op.operandA : op.operandA;
	assign bIn = op.invB ? ~op.operandB : op.operandB;

	assign {cout, sum} = {1'b0, aIn} + {1'b0, bIn} + {{WORD_W{1'b0}}, op.carryIn};

	// Flags on the adder output
	assign zero = ~|sum;
	assign neg  = sum[WORD_W-1];

	// Compares run Rt - Rs
	// Opposite signs could overflow, so the sign of Rs decides there
	assign signsDiffer = op.operandA[WORD_W-1] ^ op.operandB[WORD_W-1];
	assign lessThan    = signsDiffer ? op.operandA[WORD_W-1] : (~neg & ~zero);
	assign lessEq      = lessThan | zero;

	// Count from low bits of Rt or immediate
	shifter u_shifter (
		.shiftIn  (op.operandA),
		.shiftCnt (op.operandB[3:0]),
		.rotLeft  (rotLeft),
		.rotRight (rotRight),
		.shLeft   (shLeft),
		.shRight  (shRight),
		.bitRev   (bitRev)
	);

	always_comb begin
		result = '0;
		err    = 1'b0;
		case (op.opcode)
			ALU_1: begin
				case (op.funct)
					ADD, SUB: result = sum;
					XOR:      result = op.operandA ^ op.operandB;
					// Rt already inverted in decode
					ANDN:     result = op.operandA & bIn;
				endcase
			end
			ALU_2: begin
				case (op.funct)
					ROL: result = rotLeft;
					SLL: result = shLeft;
					ROR: result = rotRight;
					SRL: result = shRight;
				endcase
			end
			SEQ:  result = dataWord'(zero);
			SLT:  result = dataWord'(lessThan);
			SLE:  result = dataWord'(lessEq);
			// Carry of Rs + Rt
			SCO:  result = dataWord'(cout);
			BTR:  result = bitRev;

			// Immediate arithmetic and logic
			SUBI, ADDI: result = sum;
			ANDNI:      result = op.operandA & bIn;
			XORI:       result = op.operandA ^ op.operandB;
			ROLI:       result = rotLeft;
			SLLI:       result = shLeft;
			RORI:       result = rotRight;
			SRLI:       result = shRight;

			// Address sums
			ST, LD, STU, JR, JALR: result = sum;

			// Operand B is zero so this is Rs
			BNEZ, BEQZ, BLTZ, BGEZ: result = sum;

			LBI:  result = op.operandB;
			SLBI: result = (op.operandA << 8) | op.operandB;

			// No PC here
			J, JAL: result = '0;

			// Specials just produce zero
			HALT, NOP, SIIC, RTI: result = '0;

			default: err = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/execDecode.sv
`timescale 1ns/1ns
`default_nettype none

module execDecode
	import execPkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  logic     instrValid,
	input  dataWord  instr,
	input  dataWord  rsVal,
	input  dataWord  rtVal,
	output logic     decValid,
	output decodedOp decOp
);

	opCode    opc;
	dataWord  sext5, zext5, sext8, zext8;
	regIndex  destR, destI1, destI2;
	decodedOp nextOp;

	assign opc = instr[15:11];

	// Immediate forms
	assign sext5 = {{(WORD_W-5){instr[4]}}, instr[4:0]};
	assign zext5 = {{(WORD_W-5){1'b0}}, instr[4:0]};
	assign sext8 = {{(WORD_W-8){instr[7]}}, instr[7:0]};
	assign zext8 = {{(WORD_W-8){1'b0}}, instr[7:0]};

	// Destination field per format
	assign destR  = instr[4:2];
	assign destI1 = instr[7:5];
	assign destI2 = instr[10:8];

	always_comb begin
		nextOp          = '0;
		nextOp.opcode   = opc;
		nextOp.funct    = instr[1:0];
		nextOp.operandA = rsVal;
		nextOp.operandB = rtVal;
		// I-format 2 and jump layout unless overridden
		nextOp.dest     = destI2;
		case (opc)
			ALU_1: begin
				nextOp.dest = destR;
				// Rt - Rs as ~Rs + Rt + 1
				nextOp.invA    = (instr[1:0] == SUB);
				nextOp.carryIn = (instr[1:0] == SUB);
				nextOp.invB    = (instr[1:0] == ANDN);
			end
			ALU_2, BTR, SCO: begin
				nextOp.dest = destR;
			end
			SEQ, SLT, SLE: begin
				nextOp.dest    = destR;
				nextOp.invA    = 1'b1;
				nextOp.carryIn = 1'b1;
			end
			SUBI: begin
				nextOp.dest     = destI1;
				nextOp.operandB = sext5;
				nextOp.invA     = 1'b1;
				nextOp.carryIn  = 1'b1;
			end
			// Signed offsets
			ADDI, ST, LD, STU: begin
				nextOp.dest     = destI1;
				nextOp.operandB = sext5;
			end
			ANDNI: begin
				nextOp.dest     = destI1;
				nextOp.operandB = zext5;
				nextOp.invB     = 1'b1;
			end
			XORI, ROLI, SLLI, RORI, SRLI: begin
				nextOp.dest     = destI1;
				nextOp.operandB = zext5;
			end
			// Adder passes Rs so flags describe it
			BNEZ, BEQZ, BLTZ, BGEZ: nextOp.operandB = '0;
			LBI, JR, JALR:          nextOp.operandB = sext8;
			SLBI:                   nextOp.operandB = zext8;
			default:                nextOp.operandB = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			decValid <= 1'b0;
			decOp    <= '0;
		end else begin
			decValid <= instrValid;
			if (instrValid) begin
				decOp <= nextOp;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/execStage.sv
`timescale 1ns/1ns
`default_nettype none

module execStage
	import execPkg::*;
(
	input  logic      clk,
	input  logic      rstN,
	input  logic      decValid,
	input  decodedOp  decOp,
	output logic      resValid,
	output execResult res
);

	dataWord   aluResult;
	logic      aluErr, aluZero, aluNeg;
	execResult nextRes;

	alu u_alu (
		.op     (decOp),
		.result (aluResult),
		.err    (aluErr),
		.zero   (aluZero),
		.neg    (aluNeg)
	);

	always_comb begin
		nextRes.result = aluResult;
		nextRes.dest   = decOp.dest;
		nextRes.err    = aluErr;
		// Flags reflect Rs for branch opcodes
		case (decOp.opcode)
			BNEZ:    nextRes.branchTaken = ~aluZero;
			BEQZ:    nextRes.branchTaken = aluZero;
			BLTZ:    nextRes.branchTaken = aluNeg;
			BGEZ:    nextRes.branchTaken = ~aluNeg;
			default: nextRes.branchTaken = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			resValid <= 1'b0;
			res      <= '0;
		end else begin
			resValid <= decValid;
			if (decValid) begin
				res <= nextRes;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/execTop.sv
`timescale 1ns/1ns
`default_nettype none

module execTop
	import execPkg::*;
(
	input  logic      clk,
	input  logic      rstN,
	input  logic      instrValid,
	input  dataWord   instr,
	input  dataWord   rsVal,
	input  dataWord   rtVal,
	output logic      resValid,
	output execResult res
);

	// Stage 1 to stage 2
	logic     decValid;
	decodedOp decOp;

	execDecode u_execDecode (
		.clk        (clk),
		.rstN       (rstN),
		.instrValid (instrValid),
		.instr      (instr),
		.rsVal      (rsVal),
		.rtVal      (rtVal),
		.decValid   (decValid),
		.decOp      (decOp)
	);

	execStage u_execStage (
		.clk      (clk),
		.rstN     (rstN),
		.decValid (decValid),
		.decOp    (decOp),
		.resValid (resValid),
		.res      (res)
	);

endmodule

`default_nettype wire

//--- testbench/execUnit_properties.sv
`timescale 1ns/1ns
`default_nettype none

module execUnit_properties
	import execPkg::*;
(
	input logic      clk,
	input logic      rstN,
	input logic      instrValid,
	input logic      resValid,
	input execResult res
);

	// Fixed two-cycle latency once both stages are out of reset
	latencyTwo: assert property (@(posedge clk)
		($past(rstN) && $past(rstN, 2)) |-> (resValid == $past(instrValid, 2)))
		else $error("resValid is not instrValid delayed by two cycles");

	// Quiet while reset is held
	resetQuiet: assert property (@(posedge clk) !rstN |=> !resValid)
		else $error("resValid high during reset");

	// Still quiet the cycle after release
	releaseQuiet: assert property (@(posedge clk) $rose(rstN) |=> !resValid)
		else $error("resValid high right after reset release");

	// Error flag always comes with a zero word
	errZero: assert property (@(posedge clk) (resValid && res.err) |-> (res.result == '0))
		else $error("err set with a non-zero result");

endmodule

bind execTop execUnit_properties u_props (
	.clk        (clk),
	.rstN       (rstN),
	.instrValid (instrValid),
	.resValid   (resValid),
	.res        (res)
);

`default_nettype wire

//--- testbench/tbExec.sv
`timescale 1ns/1ns
`default_nettype none

module tbExec
	import execPkg::*;
();

	logic      clk;
	logic      rstN;
	logic      instrValid;
	dataWord   instr;
	dataWord   rsVal;
	dataWord   rtVal;
	logic      resValid;
	execResult res;

	// Golden vectors with one entry per file line
	logic [15:0] vecInstr[$];
	logic [15:0] vecRs[$];
	logic [15:0] vecRt[$];
	logic [15:0] vecRes[$];
	logic [15:0] vecDest[$];
	logic [15:0] vecErr[$];
	logic [15:0] vecBr[$];
	string       vecGroup[$];

	// Outstanding results in issue order
	execResult expQ[$];
	string     nameQ[$];

	execResult   pending;
	execResult   expectedRes;
	string       expectedName;
	logic [31:0] lcgState;
	int          idx;
	int          gap;
	int          drainCycles;
	int          cycleCount;
	int          cycleLimit;
	logic        endReported;

	execTop i_dut (
		.clk        (clk),
		.rstN       (rstN),
		.instrValid (instrValid),
		.instr      (instr),
		.rsVal      (rsVal),
		.rtVal      (rtVal),
		.resValid   (resValid),
		.res        (res)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState;
	endfunction

	task automatic stopWithFailure();
		endReported = 1'b1;
		$display("Finished with errors");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic checkValue(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		if (actual !== expected) begin
			$display("** Error: %s: expected %h, actual %h", name, expected, actual);
			stopWithFailure();
		end
	endtask

	// Comment lines name the group of the vectors below them
	task automatic loadGolden();
		int          fd;
		int          count;
		string       line;
		string       group;
		logic [15:0] f0, f1, f2, f3, f4, f5, f6;
		fd = $fopen("testbench/execGolden.txt", "r");
		if (fd == 0) begin
			$display("Cannot open testbench/execGolden.txt");
			stopWithFailure();
		end else begin
			group = "ungrouped";
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 3 && line.substr(0, 1) == "//") begin
					group = line.substr(3, line.len() - 2);
				end else begin
					count = $sscanf(line, "%h %h %h %h %h %h %h",
						f0, f1, f2, f3, f4, f5, f6);
					if (count == 7) begin
						vecInstr.push_back(f0);
						vecRs.push_back(f1);
						vecRt.push_back(f2);
						vecRes.push_back(f3);
						vecDest.push_back(f4);
						vecErr.push_back(f5);
						vecBr.push_back(f6);
						vecGroup.push_back(group);
					end
				end
			end
			$fclose(fd);
			if (vecInstr.size() == 0) begin
				$display("Golden file holds no test vectors");
				stopWithFailure();
			end
		end
	endtask

	// Stimulus
	initial begin
		rstN        = 1'b0;
		// Strobe held high through reset must be ignored
		instrValid  = 1'b1;
		instr       = '0;
		rsVal       = '0;
		rtVal       = '0;
		lcgState    = 32'h24ae058b;
		endReported = 1'b0;
		cycleCount  = 0;
		cycleLimit  = 0;
		loadGolden();
		cycleLimit = vecInstr.size() * 4 + 20;
		repeat (2) @(posedge clk);
		rstN       <= 1'b1;
		instrValid <= 1'b0;
		for (idx = 0; idx < vecInstr.size(); idx++) begin
			// Every other run of six goes back to back
			if (((idx / 6) % 2) == 1) begin
				gap = 0;
			end else begin
				gap = int'(nextRand() >> 16) % 3;
			end
			repeat (gap) begin
				@(posedge clk);
				instrValid <= 1'b0;
			end
			@(posedge clk);
			instrValid <= 1'b1;
			instr      <= vecInstr[idx];
			rsVal      <= vecRs[idx];
			rtVal      <= vecRt[idx];
			pending.result      = vecRes[idx];
			pending.dest        = vecDest[idx][2:0];
			pending.err         = vecErr[idx][0];
			pending.branchTaken = vecBr[idx][0];
			expQ.push_back(pending);
			nameQ.push_back($sformatf("%s vector %0d", vecGroup[idx], idx));
		end
		@(posedge clk);
		instrValid <= 1'b0;
		// Two-cycle latency plus a little slack
		drainCycles = 0;
		while (expQ.size() != 0 && drainCycles < 4) begin
			@(posedge clk);
			drainCycles++;
		end
		// Room for a stray strobe
		repeat (2) @(posedge clk);
		endReported = 1'b1;
		if (expQ.size() != 0) begin
			$display("%0d expected results never appeared on resValid", expQ.size());
			stopWithFailure();
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

	// Outputs settle after the rising edge, so sample on the falling one
	always @(negedge clk) begin
		if (resValid) begin
			if (expQ.size() == 0) begin
				$display("resValid strobed with no instruction outstanding");
				stopWithFailure();
			end else begin
				expectedRes  = expQ.pop_front();
				expectedName = nameQ.pop_front();
				checkValue({expectedName, " result"}, expectedRes.result, res.result);
				checkValue({expectedName, " dest"}, 16'(expectedRes.dest), 16'(res.dest));
				checkValue({expectedName, " err"}, 16'(expectedRes.err), 16'(res.err));
				checkValue({expectedName, " branchTaken"}, 16'(expectedRes.branchTaken),
					16'(res.branchTaken));
			end
		end
	end

	// Run length guard
	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
			$display("Timeout after %0d cycles with %0d results outstanding",
				cycleCount, expQ.size());
			stopWithFailure();
		end
	end

	// Run ended by something outside this module such as a bound assertion
	final begin
		if (!endReported) begin
			$display("Finished with errors");
		end
	end

endmodule

`default_nettype wire

//--- testbench/execGolden.txt
// Columns: instr rsVal rtVal result dest err branchTaken, all hex
// A line starting with // names the group of the vectors below it
// arithmetic and logic
D94C 1234 4321 5555 3 0 0
D955 0005 0003 FFFE 5 0 0
D95E F0F0 FF00 0FF0 7 0 0
D943 FFFF 0F0F F0F0 0 0 0
4A9F 0010 ABCD 000F 4 0 0
4A2F 7FFF ABCD 800E 1 0 0
43C4 0009 ABCD FFFB 6 0 0
5C7F 8001 0000 801E 3 0 0
55B5 FFFF 0000 FFEA 5 0 0
// shifts and rotates
D144 8001 0001 0003 1 0 0
D149 0003 00FF 8000 2 0 0
D14E 1234 0010 1234 3 0 0
D153 8000 000F 0001 4 0 0
A1EF 0001 0000 8000 7 0 0
A9C1 C001 0000 8002 6 0 0
B2A1 0001 0000 8000 5 0 0
BA81 F00F 0000 7807 4 0 0
CE08 1234 0000 2C48 2 0 0
// compares and carry
E144 8000 8000 0001 1 0 0
E140 0001 0002 0000 0 0 0
E948 FFFE FFFF 0001 2 0 0
E94C 7FFF 8000 0000 3 0 0
F150 0005 0005 0001 4 0 0
F154 8000 7FFF 0001 5 0 0
F958 8000 8000 0001 6 0 0
F95C 7FFF 8000 0000 7 0 0
// immediate loads and address sums
C380 1234 0000 FF80 3 0 0
95CD 00AB 0000 ABCD 5 0 0
815C 1000 0000 0FFC 2 0 0
8A66 2000 0000 2006 3 0 0
9C91 0010 0000 0001 4 0 0
2EF0 0100 0000 00F0 6 0 0
// branches
6104 0000 1111 0000 1 0 0
6104 0005 1111 0005 1 0 1
6A04 0000 1111 0000 2 0 1
7304 FFFF 1111 FFFF 3 0 1
7304 7FFF 1111 7FFF 3 0 0
7C04 0000 1111 0000 4 0 1
7C04 8001 1111 8001 4 0 0
// specials and jumps
0800 1234 5678 0000 0 0 0
0000 FFFF FFFF 0000 0 0 0
23AA 1234 5678 0000 3 0 0
3501 1234 5678 0000 5 0 0
1000 1234 5678 0000 0 0 0
1800 1234 5678 0000 0 0 0

//--- vlog.f
rtl/execPkg.sv
rtl/shifter.sv
rtl/alu.sv
rtl/execDecode.sv
rtl/execStage.sv
rtl/execTop.sv
testbench/execUnit_properties.sv
testbench/tbExec.sv

//--- runSim.sh
#!/bin/sh
# Build the execute-unit testbench with Verilator, run it, then check the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tbExec -f vlog.f --Mdir obj_dir

# Pipeline status is that of tee, so a failed run still reaches the log check
./obj_dir/VtbExec 2>&1 | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
